// ==== commit_cu.sv ====
`timescale 1ns/1ps

module commit_cu (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // ROB head
  input  logic                                head_valid_i,
  input  commit_pkg::rob_entry_t              head_entry_i,
  input  commit_pkg::rob_idx_t                head_idx_i,
  output logic                                head_pop_o,

  // Front end and trap vector
  input  logic                                fe_ready_i,
  input  commit_pkg::mtvec_t                  mtvec_i,

  output commit_pkg::comm_entry_t             comm_entry_o,

  // Retirement
  output logic                                rf_valid_o,
  output logic [commit_pkg::REG_IDX_LEN-1:0]  rd_idx_o,
  output logic [commit_pkg::XLEN-1:0]         rd_value_o,
  output logic                                except_raised_o,
  output logic [commit_pkg::XLEN-1:0]         except_pc_o,
  output logic                                ex_mis_flush_o,
  output logic                                except_flush_o
);

  commit_pkg::cu_state_t         state_q, state_d;
  commit_pkg::comm_type_t        head_type, comm_type_q;
  logic                          comm_valid_q;
  commit_pkg::rob_idx_t          comm_idx_q;
  commit_pkg::rob_entry_t        comm_data_q;
  logic [commit_pkg::XLEN-1:0]   trap_offset;

  // ------------------------------------------------------------------
  // Classification of the head instruction
  // ------------------------------------------------------------------
  always_comb begin : classify
    if (head_entry_i.except_raised) begin
      head_type = commit_pkg::COMM_EXCEPT;
    end else if (head_entry_i.mispredict) begin
      head_type = commit_pkg::COMM_MISPRED;
    end else if (head_entry_i.rd_write) begin
      head_type = commit_pkg::COMM_REG;
    end else begin
      head_type = commit_pkg::COMM_NONE;
    end
  end

  // Only pop while running
  assign head_pop_o = (state_q == commit_pkg::CU_RUN) && head_valid_i;

  // ------------------------------------------------------------------
  // Control FSM
  // ------------------------------------------------------------------
  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      commit_pkg::CU_RUN: begin
        if (head_pop_o && (head_type == commit_pkg::COMM_EXCEPT)) begin
          state_d = commit_pkg::CU_EXCEPT;
        end else if (head_pop_o && (head_type == commit_pkg::COMM_MISPRED)) begin
          state_d = commit_pkg::CU_FLUSH;
        end
      end
      commit_pkg::CU_FLUSH:  state_d = commit_pkg::CU_RUN;
      commit_pkg::CU_EXCEPT: begin
        if (fe_ready_i) begin
          state_d = commit_pkg::CU_RUN;
        end
      end
      default:               state_d = commit_pkg::CU_RUN;
    endcase
  end

  // Valid drops on the flush edge as no pop happens outside CU_RUN
  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      state_q      <= commit_pkg::CU_RUN;
      comm_valid_q <= 1'b0;
      comm_type_q  <= commit_pkg::COMM_NONE;
    end else begin
      state_q      <= state_d;
      comm_valid_q <= head_pop_o;
      if (head_pop_o) begin
        comm_type_q <= head_type;
      end
    end
  end

  // Committing instruction payload
  always_ff @(posedge clk_i) begin : comm_payload
    if (head_pop_o) begin
      comm_idx_q  <= head_idx_i;
      comm_data_q <= head_entry_i;
    end
  end

  assign comm_entry_o.valid   = comm_valid_q;
  assign comm_entry_o.rob_idx = comm_idx_q;
  assign comm_entry_o.entry   = comm_data_q;

  // ------------------------------------------------------------------
  // Outputs from the registered instruction
  // ------------------------------------------------------------------
  assign rf_valid_o = comm_valid_q &&
      ((comm_type_q == commit_pkg::COMM_REG) ||
       ((comm_type_q == commit_pkg::COMM_MISPRED) && comm_data_q.rd_write));
  assign rd_idx_o   = comm_data_q.rd_idx;
  assign rd_value_o = comm_data_q.value;

  assign ex_mis_flush_o  = (state_q == commit_pkg::CU_FLUSH);
  assign except_raised_o = (state_q == commit_pkg::CU_EXCEPT);
  assign except_flush_o  = except_raised_o && comm_valid_q;

  // Trap address, vectored mode adds cause * 4
  assign trap_offset = (mtvec_i.mode == 2'd1) ?
      {{(commit_pkg::XLEN - commit_pkg::EXCEPT_LEN - 2){1'b0}}, comm_data_q.except_code, 2'b00} :
      '0;
  assign except_pc_o = {mtvec_i.base, 2'b00} + trap_offset;

endmodule

// ==== commit_pkg.sv ====
package commit_pkg;

  // ------------------------------------------------------------------
  // Widths and sizes
  // ------------------------------------------------------------------
  localparam int XLEN        = 32;
  localparam int REG_IDX_LEN = 5;
  localparam int ROB_DEPTH   = 8;
  localparam int ROB_IDX_LEN = $clog2(ROB_DEPTH);
  localparam int EXCEPT_LEN  = 4;

  typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

  // ------------------------------------------------------------------
  // Bundles
  // ------------------------------------------------------------------

  // Written by issue into a fresh ROB slot
  typedef struct packed {
    logic [XLEN-1:0]        pc;
    logic [REG_IDX_LEN-1:0] rd_idx;
    logic                   rd_write;
  } issue_data_t;

  // One result on the common data bus
  typedef struct packed {
    rob_idx_t              rob_idx;
    logic [XLEN-1:0]       value;
    logic                  except_raised;
    logic [EXCEPT_LEN-1:0] except_code;
    logic                  mispredict;
  } cdb_data_t;

  typedef struct packed {
    logic [XLEN-1:0]        pc;
    logic [REG_IDX_LEN-1:0] rd_idx;
    logic                   rd_write;
    logic                   res_ready;
    logic [XLEN-1:0]        value;
    logic                   except_raised;
    logic [EXCEPT_LEN-1:0]  except_code;
    logic                   mispredict;
  } rob_entry_t;

  // Committing instruction register content
  typedef struct packed {
    logic       valid;
    rob_idx_t   rob_idx;
    rob_entry_t entry;
  } comm_entry_t;

  typedef struct packed {
    logic            ready;
    logic [XLEN-1:0] value;
  } opnd_t;

  typedef struct packed {
    logic            busy;
    logic            res_ready;
    logic [XLEN-1:0] value;
  } rob_lookup_t;

  typedef struct packed {
    logic [XLEN-3:0] base;
    logic [1:0]      mode;
  } mtvec_t;

  typedef enum logic [1:0] {
    COMM_NONE,
    COMM_REG,
    COMM_EXCEPT,
    COMM_MISPRED
  } comm_type_t;

  typedef enum logic [1:0] {
    CU_RUN,
    CU_EXCEPT,
    CU_FLUSH
  } cu_state_t;

endpackage

// ==== commit_stage.sv ====
`timescale 1ns/1ps

module commit_stage (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Issue
  input  logic                                issue_valid_i,
  output logic                                issue_ready_o,
  input  commit_pkg::issue_data_t             issue_data_i,
  output commit_pkg::rob_idx_t                issue_tail_idx_o,
  input  commit_pkg::rob_idx_t                issue_rs1_idx_i,
  input  commit_pkg::rob_idx_t                issue_rs2_idx_i,
  output commit_pkg::opnd_t                   issue_rs1_o,
  output commit_pkg::opnd_t                   issue_rs2_o,

  // Common data bus
  input  logic                                cdb_valid_i,
  input  commit_pkg::cdb_data_t               cdb_data_i,

  // Front end
  input  logic                                fe_ready_i,
  input  commit_pkg::mtvec_t                  mtvec_i,
  output logic                                except_raised_o,
  output logic [commit_pkg::XLEN-1:0]         except_pc_o,

  // Register file
  output logic                                rf_valid_o,
  output logic [commit_pkg::REG_IDX_LEN-1:0]  rd_idx_o,
  output logic [commit_pkg::XLEN-1:0]         rd_value_o,

  // Pipeline flush
  output logic                                ex_mis_flush_o,
  output logic                                except_flush_o
);

  logic                     head_valid;
  logic                     head_pop;
  commit_pkg::rob_entry_t   head_entry;
  commit_pkg::rob_idx_t     head_idx;
  commit_pkg::rob_lookup_t  rs1_lookup;
  commit_pkg::rob_lookup_t  rs2_lookup;
  commit_pkg::comm_entry_t  comm_entry;

  // Both flush kinds empty the ROB
  wire rob_flush = ex_mis_flush_o | except_flush_o;

  rob u_rob (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (rob_flush),
    .issue_valid_i    (issue_valid_i),
    .issue_ready_o    (issue_ready_o),
    .issue_data_i     (issue_data_i),
    .issue_tail_idx_o (issue_tail_idx_o),
    .cdb_valid_i      (cdb_valid_i),
    .cdb_data_i       (cdb_data_i),
    .head_valid_o     (head_valid),
    .head_entry_o     (head_entry),
    .head_idx_o       (head_idx),
    .head_pop_i       (head_pop),
    .rs1_idx_i        (issue_rs1_idx_i),
    .rs2_idx_i        (issue_rs2_idx_i),
    .rs1_lookup_o     (rs1_lookup),
    .rs2_lookup_o     (rs2_lookup)
  );

  operand_fwd u_operand_fwd (
    .cdb_valid_i  (cdb_valid_i),
    .cdb_data_i   (cdb_data_i),
    .rs1_idx_i    (issue_rs1_idx_i),
    .rs2_idx_i    (issue_rs2_idx_i),
    .rs1_lookup_i (rs1_lookup),
    .rs2_lookup_i (rs2_lookup),
    .comm_entry_i (comm_entry),
    .rs1_o        (issue_rs1_o),
    .rs2_o        (issue_rs2_o)
  );

  commit_cu u_commit_cu (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .head_valid_i    (head_valid),
    .head_entry_i    (head_entry),
    .head_idx_i      (head_idx),
    .head_pop_o      (head_pop),
    .fe_ready_i      (fe_ready_i),
    .mtvec_i         (mtvec_i),
    .comm_entry_o    (comm_entry),
    .rf_valid_o      (rf_valid_o),
    .rd_idx_o        (rd_idx_o),
    .rd_value_o      (rd_value_o),
    .except_raised_o (except_raised_o),
    .except_pc_o     (except_pc_o),
    .ex_mis_flush_o  (ex_mis_flush_o),
    .except_flush_o  (except_flush_o)
  );

endmodule

// ==== list.f ====
commit_pkg.sv
rob.sv
operand_fwd.sv
commit_cu.sv
commit_stage.sv
tb_commit_stage.sv

// ==== operand_fwd.sv ====
`timescale 1ns/1ps

module operand_fwd (
  input  logic                     cdb_valid_i,
  input  commit_pkg::cdb_data_t    cdb_data_i,
  input  commit_pkg::rob_idx_t     rs1_idx_i,
  input  commit_pkg::rob_idx_t     rs2_idx_i,
  input  commit_pkg::rob_lookup_t  rs1_lookup_i,
  input  commit_pkg::rob_lookup_t  rs2_lookup_i,
  input  commit_pkg::comm_entry_t  comm_entry_i,
  output commit_pkg::opnd_t        rs1_o,
  output commit_pkg::opnd_t        rs2_o
);

  // Newest source first: CDB, then ROB slot, then committing register
  function automatic commit_pkg::opnd_t select_opnd(
    input commit_pkg::rob_idx_t    idx,
    input commit_pkg::rob_lookup_t lk,
    input logic                    cdb_valid,
    input commit_pkg::cdb_data_t   cdb,
    input commit_pkg::comm_entry_t comm
  );
    commit_pkg::opnd_t op;
    if (cdb_valid && (cdb.rob_idx == idx)) begin
      op.ready = 1'b1;
      op.value = cdb.value;
    end else if (lk.busy) begin
      // Slot still in flight, result may be pending
      op.ready = lk.res_ready;
      op.value = lk.value;
    end else if (comm.valid && (comm.rob_idx == idx)) begin
      op.ready = 1'b1;
      op.value = comm.entry.value;
    end else begin
      op.ready = 1'b0;
      op.value = '0;
    end
    return op;
  endfunction

  assign rs1_o = select_opnd(rs1_idx_i, rs1_lookup_i, cdb_valid_i, cdb_data_i, comm_entry_i);
  assign rs2_o = select_opnd(rs2_idx_i, rs2_lookup_i, cdb_valid_i, cdb_data_i, comm_entry_i);

endmodule

// ==== rob.sv ====
`timescale 1ns/1ps

module rob (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,

  // Issue side
  input  logic                     issue_valid_i,
  output logic                     issue_ready_o,
  input  commit_pkg::issue_data_t  issue_data_i,
  output commit_pkg::rob_idx_t     issue_tail_idx_o,

  // Result write-back
  input  logic                     cdb_valid_i,
  input  commit_pkg::cdb_data_t    cdb_data_i,

  // Head towards the commit control
  output logic                     head_valid_o,
  output commit_pkg::rob_entry_t   head_entry_o,
  output commit_pkg::rob_idx_t     head_idx_o,
  input  logic                     head_pop_i,

  // Operand lookup
  input  commit_pkg::rob_idx_t     rs1_idx_i,
  input  commit_pkg::rob_idx_t     rs2_idx_i,
  output commit_pkg::rob_lookup_t  rs1_lookup_o,
  output commit_pkg::rob_lookup_t  rs2_lookup_o
);

  typedef logic [commit_pkg::ROB_IDX_LEN:0] cnt_t;

  localparam cnt_t FULL_CNT = cnt_t'(commit_pkg::ROB_DEPTH);

  commit_pkg::rob_entry_t                   data_q [commit_pkg::ROB_DEPTH];
  logic [commit_pkg::ROB_DEPTH-1:0]         busy_q;
  commit_pkg::rob_idx_t                     head_q;
  commit_pkg::rob_idx_t                     tail_q;
  cnt_t                                     cnt_q;
  logic                                     issue_accept;

  function automatic commit_pkg::rob_idx_t next_ptr(input commit_pkg::rob_idx_t ptr);
    if (ptr == commit_pkg::rob_idx_t'(commit_pkg::ROB_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  function automatic commit_pkg::rob_lookup_t read_slot(
    input logic                   busy,
    input commit_pkg::rob_entry_t entry
  );
    commit_pkg::rob_lookup_t lk;
    lk.busy      = busy;
    lk.res_ready = busy & entry.res_ready;
    lk.value     = entry.value;
    return lk;
  endfunction

  assign issue_ready_o    = (cnt_q != FULL_CNT);
  assign issue_accept     = issue_valid_i && issue_ready_o;
  assign issue_tail_idx_o = tail_q;

  // ------------------------------------------------------------------
  // Pointers, occupancy and busy bits
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : rob_ctrl
    if (!rst_ni) begin
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= '0;
      busy_q <= '0;
    end else if (flush_i) begin
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= '0;
      busy_q <= '0;
    end else begin
      if (head_pop_i) begin
        busy_q[head_q] <= 1'b0;
        head_q         <= next_ptr(head_q);
      end
      if (issue_accept) begin
        busy_q[tail_q] <= 1'b1;
        tail_q         <= next_ptr(tail_q);
      end
      case ({issue_accept, head_pop_i})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Slot contents
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin : rob_data
    if (issue_accept) begin
      data_q[tail_q].pc            <= issue_data_i.pc;
      data_q[tail_q].rd_idx        <= issue_data_i.rd_idx;
      data_q[tail_q].rd_write      <= issue_data_i.rd_write;
      data_q[tail_q].res_ready     <= 1'b0;
      data_q[tail_q].value         <= '0;
      data_q[tail_q].except_raised <= 1'b0;
      data_q[tail_q].except_code   <= '0;
      data_q[tail_q].mispredict    <= 1'b0;
    end
    // Results for freed slots are stale and dropped
    if (cdb_valid_i && busy_q[cdb_data_i.rob_idx]) begin
      data_q[cdb_data_i.rob_idx].res_ready     <= 1'b1;
      data_q[cdb_data_i.rob_idx].value         <= cdb_data_i.value;
      data_q[cdb_data_i.rob_idx].except_raised <= cdb_data_i.except_raised;
      data_q[cdb_data_i.rob_idx].except_code   <= cdb_data_i.except_code;
      data_q[cdb_data_i.rob_idx].mispredict    <= cdb_data_i.mispredict;
    end
  end

  // Head is committable once its result is in
  assign head_valid_o = busy_q[head_q] && data_q[head_q].res_ready;
  assign head_entry_o = data_q[head_q];
  assign head_idx_o   = head_q;

  assign rs1_lookup_o = read_slot(busy_q[rs1_idx_i], data_q[rs1_idx_i]);
  assign rs2_lookup_o = read_slot(busy_q[rs2_idx_i], data_q[rs2_idx_i]);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the commit stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_commit_stage -f list.f -o tb_sim; then
  echo "build failed"
  exit 1
fi

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "^test passed$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb_commit_stage.sv ====
`timescale 1ns/1ps

module tb_commit_stage;

  localparam int N_INSTR     = 39;
  localparam int WATCHDOG_NS = 200 * N_INSTR * 10;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          issue_valid_i;
  logic                          issue_ready_o;
  commit_pkg::issue_data_t       issue_data_i;
  commit_pkg::rob_idx_t          issue_tail_idx_o;
  commit_pkg::rob_idx_t          issue_rs1_idx_i;
  commit_pkg::rob_idx_t          issue_rs2_idx_i;
  commit_pkg::opnd_t             issue_rs1_o;
  commit_pkg::opnd_t             issue_rs2_o;
  logic                          cdb_valid_i;
  commit_pkg::cdb_data_t         cdb_data_i;
  logic                          fe_ready_i;
  commit_pkg::mtvec_t            mtvec_i;
  logic                          except_raised_o;
  logic [31:0]                   except_pc_o;
  logic                          rf_valid_o;
  logic [4:0]                    rd_idx_o;
  logic [31:0]                   rd_value_o;
  logic                          ex_mis_flush_o;
  logic                          except_flush_o;

  integer                        seed = 32'hb668011f;
  // Reference model, indexed by ROB slot
  logic [4:0]                    m_rd [8];
  logic [31:0]                   m_val [8];
  // Slots that must produce an rf_valid_o pulse, oldest first
  commit_pkg::rob_idx_t          pulse_q [$];

  commit_stage dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  task automatic fail_run(input string what);
    $display("ERROR time=%0t %s", $time, what);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_val(name, 32'(exp), 32'(act));
  endtask

  task automatic check_opnd(input string name, input logic rdy, input logic [31:0] val,
                            input commit_pkg::opnd_t act);
    check_bit({name, ".ready"}, rdy, act.ready);
    check_val({name, ".value"}, val, act.value);
  endtask

  // ------------------------------------------------------------------
  // Retirement monitor and pulse checks
  // ------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni && rf_valid_o) begin
      if (pulse_q.size() == 0) begin
        fail_run("register write with no instruction left to retire");
      end else begin
        check_val("rd_idx_o", 32'(m_rd[pulse_q[0]]), 32'(rd_idx_o));
        check_val("rd_value_o", m_val[pulse_q[0]], rd_value_o);
        void'(pulse_q.pop_front());
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) except_flush_o |=> !except_flush_o)
    else fail_run("except_flush_o held longer than one cycle");
  assert property (@(posedge clk_i) disable iff (!rst_ni) ex_mis_flush_o |=> !ex_mis_flush_o)
    else fail_run("ex_mis_flush_o held longer than one cycle");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   except_flush_o == $rose(except_raised_o))
    else fail_run("except_flush_o did not pulse with the rise of except_raised_o");

  initial begin
    #(WATCHDOG_NS);
    fail_run("watchdog expired before the tests finished");
  end

  // ------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------
  task automatic issue_instr(input logic wr, input logic expect_pulse,
                             output commit_pkg::rob_idx_t tag);
    commit_pkg::issue_data_t d;
    logic [31:0]             r;
    r = rand32();
    d.pc       = rand32();
    d.rd_idx   = r[4:0];
    d.rd_write = wr;
    @(posedge clk_i);
    issue_valid_i <= 1'b1;
    issue_data_i  <= d;
    @(negedge clk_i);
    check_bit("issue_ready_o", 1'b1, issue_ready_o);
    tag       = issue_tail_idx_o;
    m_rd[tag] = r[4:0];
    if (expect_pulse) begin
      pulse_q.push_back(tag);
    end
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
  endtask

  task automatic send_result(input commit_pkg::rob_idx_t tag, input logic exc,
                             input logic [3:0] code, input logic mis);
    commit_pkg::cdb_data_t c;
    c.rob_idx       = tag;
    c.value         = rand32();
    c.except_raised = exc;
    c.except_code   = code;
    c.mispredict    = mis;
    m_val[tag]      = c.value;
    @(posedge clk_i);
    cdb_valid_i <= 1'b1;
    cdb_data_i  <= c;
    @(posedge clk_i);
    cdb_valid_i <= 1'b0;
  endtask

  task automatic shuffle_tags(ref commit_pkg::rob_idx_t tags [$]);
    commit_pkg::rob_idx_t t;
    int                   j;
    for (int i = tags.size() - 1; i > 0; i--) begin
      j       = int'(rand32() % 32'(i + 1));
      t       = tags[i];
      tags[i] = tags[j];
      tags[j] = t;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pulse_q.size() != 0) begin
      @(negedge clk_i);
      n++;
      if (n > 200) begin
        fail_run("instructions did not retire in time");
      end
    end
    // Trailing entries without rd_write retire within two cycles
    repeat (4) @(negedge clk_i);
  endtask

  task automatic run_batch(input int count);
    commit_pkg::rob_idx_t tags [$];
    commit_pkg::rob_idx_t t;
    logic [31:0]          r;
    for (int i = 0; i < count; i++) begin
      r = rand32();
      // Last one writes so the drain has a visible end
      issue_instr(r[0] || (i == count - 1), r[0] || (i == count - 1), t);
      tags.push_back(t);
    end
    shuffle_tags(tags);
    foreach (tags[i]) send_result(tags[i], 1'b0, 4'd0, 1'b0);
    wait_drain();
  endtask

  task automatic run_capacity();
    commit_pkg::rob_idx_t tags [$];
    commit_pkg::rob_idx_t t;
    int                   n;
    for (int i = 0; i < commit_pkg::ROB_DEPTH; i++) begin
      issue_instr(1'b1, 1'b1, t);
      tags.push_back(t);
    end
    repeat (5) begin
      @(negedge clk_i);
      check_bit("issue_ready_o", 1'b0, issue_ready_o);
    end
    send_result(tags.pop_front(), 1'b0, 4'd0, 1'b0);
    n = 0;
    @(negedge clk_i);
    while (!issue_ready_o) begin
      n++;
      if (n > 10) begin
        fail_run("issue_ready_o stayed low after the head retired");
      end
      @(negedge clk_i);
    end
    shuffle_tags(tags);
    foreach (tags[i]) send_result(tags[i], 1'b0, 4'd0, 1'b0);
    wait_drain();
  endtask

  task automatic run_forwarding();
    commit_pkg::rob_idx_t a, b, c;
    commit_pkg::cdb_data_t d;
    int                    n;
    issue_instr(1'b1, 1'b1, a);
    issue_instr(1'b1, 1'b1, b);
    @(negedge clk_i);
    c = issue_tail_idx_o;
    // Free slot and busy slot without result
    @(posedge clk_i);
    issue_rs1_idx_i <= c;
    issue_rs2_idx_i <= a;
    @(negedge clk_i);
    check_opnd("issue_rs1_o", 1'b0, 32'd0, issue_rs1_o);
    check_opnd("issue_rs2_o", 1'b0, 32'd0, issue_rs2_o);
    // CDB wins over the ROB slot
    d          = '0;
    d.rob_idx  = b;
    d.value    = rand32();
    m_val[b]   = d.value;
    @(posedge clk_i);
    cdb_valid_i     <= 1'b1;
    cdb_data_i      <= d;
    issue_rs1_idx_i <= a;
    issue_rs2_idx_i <= b;
    @(negedge clk_i);
    check_opnd("issue_rs2_o", 1'b1, m_val[b], issue_rs2_o);
    check_opnd("issue_rs1_o", 1'b0, 32'd0, issue_rs1_o);
    @(posedge clk_i);
    cdb_valid_i <= 1'b0;
    @(negedge clk_i);
    check_opnd("issue_rs2_o", 1'b1, m_val[b], issue_rs2_o);
    // Committing register answers for the slot just freed
    send_result(a, 1'b0, 4'd0, 1'b0);
    n = 0;
    @(negedge clk_i);
    while (!rf_valid_o) begin
      n++;
      if (n > 10) begin
        fail_run("head did not retire for the forwarding check");
      end
      @(negedge clk_i);
    end
    check_opnd("issue_rs1_o", 1'b1, m_val[a], issue_rs1_o);
    check_opnd("issue_rs2_o", 1'b1, m_val[b], issue_rs2_o);
    wait_drain();
  endtask

  task automatic run_exception(input logic [1:0] mode);
    commit_pkg::rob_idx_t tx, te, ty, tz;
    logic [31:0]          r;
    logic [31:0]          base;
    logic [3:0]           cause;
    logic [31:0]          exp_pc;
    int                   n;
    r     = rand32();
    base  = 32'(r[29:0]);
    cause = {r[31:30], r[31:30]};
    @(posedge clk_i);
    mtvec_i    <= {r[29:0], mode};
    fe_ready_i <= 1'b0;
    issue_instr(1'b1, 1'b1, tx);
    issue_instr(1'b1, 1'b0, te);
    issue_instr(1'b1, 1'b0, ty);
    issue_instr(1'b1, 1'b0, tz);
    // Direct mode jumps to base, vectored mode adds four bytes per cause
    exp_pc = base * 32'd4;
    if (mode == 2'd1) begin
      exp_pc = exp_pc + 32'(cause) * 32'd4;
    end
    send_result(ty, 1'b0, 4'd0, 1'b0);
    send_result(tz, 1'b0, 4'd0, 1'b0);
    send_result(te, 1'b1, cause, 1'b0);
    send_result(tx, 1'b0, 4'd0, 1'b0);
    n = 0;
    @(negedge clk_i);
    while (!except_raised_o) begin
      n++;
      if (n > 20) begin
        fail_run("exception was never raised");
      end
      @(negedge clk_i);
    end
    check_bit("except_flush_o", 1'b1, except_flush_o);
    check_val("except_pc_o", exp_pc, except_pc_o);
    repeat (3) begin
      @(negedge clk_i);
      check_bit("except_raised_o", 1'b1, except_raised_o);
    end
    @(posedge clk_i);
    fe_ready_i <= 1'b1;
    @(negedge clk_i);
    check_bit("except_raised_o", 1'b1, except_raised_o);
    @(negedge clk_i);
    check_bit("except_raised_o", 1'b0, except_raised_o);
    check_val("issue_tail_idx_o", 32'd0, 32'(issue_tail_idx_o));
    repeat (4) @(negedge clk_i);
    check_val("pending retirements", 32'd0, 32'(pulse_q.size()));
  endtask

  task automatic run_mispredict();
    commit_pkg::rob_idx_t tm, t1, t2;
    int                   n;
    issue_instr(1'b1, 1'b1, tm);
    issue_instr(1'b1, 1'b0, t1);
    issue_instr(1'b1, 1'b0, t2);
    send_result(t1, 1'b0, 4'd0, 1'b0);
    send_result(t2, 1'b0, 4'd0, 1'b0);
    send_result(tm, 1'b0, 4'd0, 1'b1);
    n = 0;
    @(negedge clk_i);
    while (!ex_mis_flush_o) begin
      n++;
      if (n > 20) begin
        fail_run("mispredict flush never came");
      end
      @(negedge clk_i);
    end
    check_bit("rf_valid_o", 1'b1, rf_valid_o);
    @(negedge clk_i);
    check_val("issue_tail_idx_o", 32'd0, 32'(issue_tail_idx_o));
    repeat (4) @(negedge clk_i);
    check_val("pending retirements", 32'd0, 32'(pulse_q.size()));
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    rst_ni          = 1'b0;
    issue_valid_i   = 1'b0;
    issue_data_i    = '0;
    issue_rs1_idx_i = '0;
    issue_rs2_idx_i = '0;
    cdb_valid_i     = 1'b0;
    cdb_data_i      = '0;
    fe_ready_i      = 1'b1;
    mtvec_i         = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    check_bit("rf_valid_o", 1'b0, rf_valid_o);
    check_bit("except_raised_o", 1'b0, except_raised_o);
    check_bit("except_flush_o", 1'b0, except_flush_o);
    check_bit("ex_mis_flush_o", 1'b0, ex_mis_flush_o);
    check_bit("issue_ready_o", 1'b1, issue_ready_o);

    repeat (3) run_batch(6);
    run_capacity();
    run_forwarding();
    run_exception(2'd0);
    run_exception(2'd1);
    run_mispredict();

    if (pulse_q.size() != 0) begin
      fail_run("instructions left unretired at the end");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule
